// File: include/sd_dac_cfg.svh
// ------------------------------
// Sigma-delta DAC configuration
// Widths, feedback step, bus address size and program length
// ------------------------------
`ifndef SD_DAC_CFG_SVH
`define SD_DAC_CFG_SVH

// Signed input sample width
`define SD_SAMPLE_W 18

// Accumulator and integrator width
`define SD_ACC_W 48

// Feedback step added or removed each stage
`define SD_DELTA 'h18000

// Wishbone byte address width
`define SD_WB_AW 4

// Number of microcode words
`define SD_UCODE_LEN 10

`endif

// File: src/sd_dac_pkg.sv
// ------------------------------
// Sigma-delta DAC shared types
// Opmodes, micro-operations, sample pairs and Wishbone structs
// ------------------------------
`include "sd_dac_cfg.svh"

package sd_dac_pkg;

    // ALU operation, 2 bits
    typedef enum logic [1:0] {
        op_nop,
        op_load_add,
        op_acc_add,
        op_acc_sub
    } opmode_e;

    // Operand source for the ALU
    typedef enum logic [1:0] {
        src_integ1,
        src_integ2,
        src_delta
    } src_e;

    // One microcode word
    typedef struct packed {
        opmode_e op;
        logic    chan;
        src_e    src;
        logic    we_integ1;
        logic    we_integ2;
        logic    we_sign;
        logic    we_dout;
        logic    delta_from_sign;
    } uop_t;

    typedef struct packed {
        logic signed [`SD_SAMPLE_W-1:0] left;
        logic signed [`SD_SAMPLE_W-1:0] right;
    } sample_pair_t;

    // ------------------------------
    // Wishbone classic
    // ------------------------------
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`SD_WB_AW-1:0] adr;
        logic [31:0]          dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

// File: src/sd_wb_regs.sv
// ------------------------------
// Wishbone register block
// Staged and committed samples, pending and overrun status
// ------------------------------
`include "sd_dac_cfg.svh"

module sd_wb_regs (
    input  logic                     reset,
    input  logic                     clk,
    input  sd_dac_pkg::wb_req_t      wb_req,
    output sd_dac_pkg::wb_rsp_t      wb_rsp,
    input  logic                     take,
    output logic                     pending,
    output sd_dac_pkg::sample_pair_t samples
);

    localparam logic [1:0] reg_left   = 2'd0;
    localparam logic [1:0] reg_right  = 2'd1;
    localparam logic [1:0] reg_commit = 2'd2;
    localparam logic [1:0] reg_status = 2'd3;

    sd_dac_pkg::sample_pair_t staged;
    logic                     ack_q;
    logic                     served_q;
    logic                     overrun_q;
    logic [31:0]              rdat_q;
    logic [1:0]               reg_sel;
    logic                     access;
    logic                     wr;
    logic                     rd;
    logic                     commit;
    logic                     status_rd;

    function automatic logic [31:0] sext32(input logic signed [`SD_SAMPLE_W-1:0] s);
        return {{(32 - `SD_SAMPLE_W){s[`SD_SAMPLE_W-1]}}, s};
    endfunction

    // One access per strobe, answered the next cycle
    assign access    = wb_req.cyc & wb_req.stb & ~ack_q & ~served_q;
    assign reg_sel   = wb_req.adr[3:2];
    assign wr        = access & wb_req.we;
    assign rd        = access & ~wb_req.we;
    assign commit    = wr & (reg_sel == reg_commit);
    assign status_rd = rd & (reg_sel == reg_status);

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

    // ------------------------------
    // Handshake
    // ------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            ack_q    <= 1'b0;
            served_q <= 1'b0;
        end else begin
            ack_q <= access;
            // Held until the strobe drops
            served_q <= wb_req.cyc & wb_req.stb & (served_q | ack_q);
        end
    end

    // Sample staging and commit copy
    always_ff @(posedge reset) begin
        if (wr && reg_sel == reg_left) begin
            staged.left <= wb_req.dat[`SD_SAMPLE_W-1:0];
        end
        if (wr && reg_sel == reg_right) begin
            staged.right <= wb_req.dat[`SD_SAMPLE_W-1:0];
        end
        if (commit) begin
            samples <= staged;
        end
    end

    // Read mux
    always_ff @(posedge reset) begin
        if (rd) begin
            case (reg_sel)
                reg_left:   rdat_q <= sext32(staged.left);
                reg_right:  rdat_q <= sext32(staged.right);
                reg_status: rdat_q <= {30'd0, overrun_q, pending};
                default:    rdat_q <= 32'd0;
            endcase
        end
    end

    // ------------------------------
    // Pending and overrun
    // ------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pending   <= 1'b0;
            overrun_q <= 1'b0;
        end else begin
            // Commit wins over take in the same cycle
            if (commit) begin
                pending <= 1'b1;
            end else if (take) begin
                pending <= 1'b0;
            end
            if (commit && pending) begin
                overrun_q <= 1'b1;
            end else if (status_rd) begin
                overrun_q <= 1'b0;
            end
        end
    end

endmodule

// File: src/sd_sequencer.sv
// ------------------------------
// Microcode sequencer
// Waits for a pending frame, then steps through the two-channel program
// ------------------------------
`include "sd_dac_cfg.svh"

module sd_sequencer (
    input  logic             reset,
    input  logic             clk,
    input  logic             pending,
    output logic             take,
    output sd_dac_pkg::uop_t uop
);

    localparam logic [3:0] last_step = 4'(`SD_UCODE_LEN - 1);

    logic [3:0] pc;

    // Frame accepted while parked at the wait step
    assign take = (pc == 4'd0) && pending;

    // ------------------------------
    // Program counter
    // ------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pc <= 4'd0;
        end else if (pc == 4'd0) begin
            if (pending) begin
                pc <= 4'd1;
            end
        end else if (pc == last_step) begin
            pc <= 4'd0;
        end else begin
            pc <= pc + 4'd1;
        end
    end

    // ------------------------------
    // Microcode ROM
    // ------------------------------
    always_comb begin
        uop = '0;
        case (pc)
            // Left: integ1 plus sample
            4'd1: begin
                uop.op  = sd_dac_pkg::op_load_add;
                uop.src = sd_dac_pkg::src_integ1;
            end
            4'd2: begin
                uop.op              = sd_dac_pkg::op_acc_add;
                uop.src             = sd_dac_pkg::src_delta;
                uop.delta_from_sign = 1'b1;
            end
            4'd3: begin
                uop.op        = sd_dac_pkg::op_acc_add;
                uop.src       = sd_dac_pkg::src_integ2;
                uop.we_integ1 = 1'b1;
            end
            4'd4: begin
                uop.op              = sd_dac_pkg::op_acc_add;
                uop.src             = sd_dac_pkg::src_delta;
                uop.delta_from_sign = 1'b1;
            end
            // Left result lands, right channel starts
            4'd5: begin
                uop.op        = sd_dac_pkg::op_load_add;
                uop.chan      = 1'b1;
                uop.src       = sd_dac_pkg::src_integ1;
                uop.we_integ2 = 1'b1;
                uop.we_sign   = 1'b1;
                uop.we_dout   = 1'b1;
            end
            4'd6: begin
                uop.op              = sd_dac_pkg::op_acc_add;
                uop.chan            = 1'b1;
                uop.src             = sd_dac_pkg::src_delta;
                uop.delta_from_sign = 1'b1;
            end
            4'd7: begin
                uop.op        = sd_dac_pkg::op_acc_add;
                uop.chan      = 1'b1;
                uop.src       = sd_dac_pkg::src_integ2;
                uop.we_integ1 = 1'b1;
            end
            4'd8: begin
                uop.op              = sd_dac_pkg::op_acc_add;
                uop.chan            = 1'b1;
                uop.src             = sd_dac_pkg::src_delta;
                uop.delta_from_sign = 1'b1;
            end
            // Right result lands, no arithmetic
            4'd9: begin
                uop.chan      = 1'b1;
                uop.we_integ2 = 1'b1;
                uop.we_sign   = 1'b1;
                uop.we_dout   = 1'b1;
            end
            default: begin
                uop = '0;
            end
        endcase
    end

endmodule

// File: src/sd_accum_alu.sv
// ------------------------------
// Accumulator ALU
// Registered add/subtract with operand chosen by opmode
// ------------------------------
`include "sd_dac_cfg.svh"

module sd_accum_alu (
    input  logic                           reset,
    input  logic                           clk,
    input  sd_dac_pkg::opmode_e            opmode,
    input  logic signed [`SD_ACC_W-1:0]    operand,
    input  logic signed [`SD_SAMPLE_W-1:0] sample,
    output logic signed [`SD_ACC_W-1:0]    p
);

    logic signed [`SD_ACC_W-1:0] sample_ext;
    logic signed [`SD_ACC_W-1:0] p_next;

    assign sample_ext = {{(`SD_ACC_W - `SD_SAMPLE_W){sample[`SD_SAMPLE_W-1]}}, sample};

    // ------------------------------
    // Operation select
    // ------------------------------
    always_comb begin
        case (opmode)
            sd_dac_pkg::op_load_add: p_next = operand + sample_ext;
            sd_dac_pkg::op_acc_add:  p_next = p + operand;
            sd_dac_pkg::op_acc_sub:  p_next = p - operand;
            // Nop keeps the accumulator
            default:                 p_next = p;
        endcase
    end

    // Result available one cycle after the operation
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            p <= '0;
        end else begin
            p <= p_next;
        end
    end

endmodule

// File: src/sd_loop_state.sv
// ------------------------------
// Per-channel modulator state
// Integrators, feedback signs, operand select and output bits
// ------------------------------
`include "sd_dac_cfg.svh"

module sd_loop_state (
    input  logic                           reset,
    input  logic                           clk,
    input  sd_dac_pkg::uop_t               uop,
    input  sd_dac_pkg::sample_pair_t       samples,
    input  logic signed [`SD_ACC_W-1:0]    p,
    output sd_dac_pkg::opmode_e            opmode,
    output logic signed [`SD_ACC_W-1:0]    operand,
    output logic signed [`SD_SAMPLE_W-1:0] sample,
    output logic                           dout_l,
    output logic                           dout_r
);

    localparam logic signed [`SD_ACC_W-1:0] delta_step = `SD_DELTA;

    logic signed [`SD_ACC_W-1:0] integ1_l;
    logic signed [`SD_ACC_W-1:0] integ1_r;
    logic signed [`SD_ACC_W-1:0] integ2_l;
    logic signed [`SD_ACC_W-1:0] integ2_r;
    logic                        sign_l;
    logic                        sign_r;
    logic                        wr_chan;

    // ------------------------------
    // Operand and direction
    // ------------------------------
    always_comb begin
        sample = uop.chan ? samples.right : samples.left;
        case (uop.src)
            sd_dac_pkg::src_integ1: operand = uop.chan ? integ1_r : integ1_l;
            sd_dac_pkg::src_integ2: operand = uop.chan ? integ2_r : integ2_l;
            sd_dac_pkg::src_delta:  operand = delta_step;
            default:                operand = '0;
        endcase
        // Negative loop value pulls up, positive pulls down
        if (uop.delta_from_sign) begin
            opmode = (uop.chan ? sign_r : sign_l) ? sd_dac_pkg::op_acc_add
                                                  : sd_dac_pkg::op_acc_sub;
        end else begin
            opmode = uop.op;
        end
    end

    // ------------------------------
    // Write-back of p
    // ------------------------------
    // p belongs to the channel of the previous uop
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_chan  <= 1'b0;
            integ1_l <= '0;
            integ1_r <= '0;
            integ2_l <= '0;
            integ2_r <= '0;
            sign_l   <= 1'b0;
            sign_r   <= 1'b0;
            dout_l   <= 1'b0;
            dout_r   <= 1'b0;
        end else begin
            wr_chan <= uop.chan;
            if (uop.we_integ1 && !wr_chan) integ1_l <= p;
            if (uop.we_integ1 && wr_chan)  integ1_r <= p;
            if (uop.we_integ2 && !wr_chan) integ2_l <= p;
            if (uop.we_integ2 && wr_chan)  integ2_r <= p;
            if (uop.we_sign && !wr_chan)   sign_l   <= p[`SD_ACC_W-1];
            if (uop.we_sign && wr_chan)    sign_r   <= p[`SD_ACC_W-1];
            // Output is one when the loop value is non-negative
            if (uop.we_dout && !wr_chan)   dout_l   <= ~p[`SD_ACC_W-1];
            if (uop.we_dout && wr_chan)    dout_r   <= ~p[`SD_ACC_W-1];
        end
    end

endmodule

// File: src/sd_dac_top.sv
// ------------------------------
// Stereo sigma-delta DAC top
// Bus registers, sequencer, ALU and loop state
// ------------------------------
`include "sd_dac_cfg.svh"

module sd_dac_top (
    input  logic                reset,
    input  logic                clk,
    input  sd_dac_pkg::wb_req_t wb_req,
    output sd_dac_pkg::wb_rsp_t wb_rsp,
    output logic                dout_l,
    output logic                dout_r
);

    logic                           pending;
    logic                           take;
    sd_dac_pkg::sample_pair_t       samples;
    sd_dac_pkg::uop_t               uop;
    sd_dac_pkg::opmode_e            alu_op;
    logic signed [`SD_ACC_W-1:0]    alu_operand;
    logic signed [`SD_SAMPLE_W-1:0] alu_sample;
    logic signed [`SD_ACC_W-1:0]    p;

    sd_wb_regs u_regs (
        .reset   (reset),
        .clk     (clk),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .take    (take),
        .pending (pending),
        .samples (samples)
    );

    sd_sequencer u_seq (
        .reset   (reset),
        .clk     (clk),
        .pending (pending),
        .take    (take),
        .uop     (uop)
    );

    // Shared 48-bit adder for both channels
    sd_accum_alu u_alu (
        .reset   (reset),
        .clk     (clk),
        .opmode  (alu_op),
        .operand (alu_operand),
        .sample  (alu_sample),
        .p       (p)
    );

    sd_loop_state u_loop (
        .reset   (reset),
        .clk     (clk),
        .uop     (uop),
        .samples (samples),
        .p       (p),
        .opmode  (alu_op),
        .operand (alu_operand),
        .sample  (alu_sample),
        .dout_l  (dout_l),
        .dout_r  (dout_r)
    );

endmodule

// File: tb/sd_dac_chk.sv
// ------------------------------
// DAC protocol and timing checks
// Bus handshake, output timing and reset state
// ------------------------------
module sd_dac_chk (
    input logic                reset,
    input logic                clk,
    input sd_dac_pkg::wb_req_t wb_req,
    input sd_dac_pkg::wb_rsp_t wb_rsp,
    input logic                take,
    input logic                pending,
    input logic                dout_l,
    input logic                dout_r
);

    int   fail_cnt = 0;
    logic strobe;

    assign strobe = wb_req.cyc & wb_req.stb;

    // ------------------------------
    // Wishbone handshake
    // ------------------------------
    ack_after_strobe: assert property (@(posedge reset) disable iff (clk)
        $rose(strobe) |=> wb_rsp.ack)
        else begin
            $error("ack missing one cycle after cyc and stb");
            fail_cnt++;
        end

    ack_one_cycle: assert property (@(posedge reset) disable iff (clk)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack high for more than one cycle");
            fail_cnt++;
        end

    ack_needs_strobe: assert property (@(posedge reset) disable iff (clk)
        wb_rsp.ack |-> $past(strobe))
        else begin
            $error("ack without a preceding strobe");
            fail_cnt++;
        end

    // ------------------------------
    // Sequencer and output timing
    // ------------------------------
    // Left bit is written at the edge ending step 5
    dout_l_timing: assert property (@(posedge reset) disable iff (clk)
        (dout_l != $past(dout_l)) |-> $past(take, 6))
        else begin
            $error("dout_l changed outside its slot after take");
            fail_cnt++;
        end

    dout_r_timing: assert property (@(posedge reset) disable iff (clk)
        (dout_r != $past(dout_r)) |-> $past(take, 10))
        else begin
            $error("dout_r changed outside its slot after take");
            fail_cnt++;
        end

    // Held reset leaves all control outputs low
    reset_state: assert property (@(posedge reset)
        (clk && $past(clk)) |-> (!take && !pending && !wb_rsp.ack && !dout_l && !dout_r))
        else begin
            $error("control outputs not low during reset");
            fail_cnt++;
        end

endmodule

bind sd_dac_top sd_dac_chk u_chk (
    .reset   (reset),
    .clk     (clk),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .take    (take),
    .pending (pending),
    .dout_l  (dout_l),
    .dout_r  (dout_r)
);

// File: tb/sd_dac_tb.sv
// ------------------------------
// Sigma-delta DAC testbench
// Wishbone traffic, density, overrun and readback checks
// ------------------------------
`include "sd_dac_cfg.svh"

module sd_dac_tb;

    localparam int ack_timeout   = 16;
    localparam int poll_limit    = 64;
    localparam int settle_frames = 64;
    localparam int count_frames  = 512;
    localparam int random_ops    = 300;

    localparam logic [3:0] adr_left   = 4'h0;
    localparam logic [3:0] adr_right  = 4'h4;
    localparam logic [3:0] adr_commit = 4'h8;
    localparam logic [3:0] adr_status = 4'hc;

    // Clock is named reset, reset is named clk
    logic                    reset;
    logic                    clk;
    sd_dac_pkg::wb_req_t     wb_req;
    sd_dac_pkg::wb_rsp_t     wb_rsp;
    logic                    dout_l;
    logic                    dout_r;
    int                      err_cnt;
    logic [`SD_SAMPLE_W-1:0] shadow_left;
    logic [`SD_SAMPLE_W-1:0] shadow_right;

    sd_dac_top UUT (
        .reset  (reset),
        .clk    (clk),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .dout_l (dout_l),
        .dout_r (dout_r)
    );

    initial begin
        reset = 1'b0;
        forever #2 reset = ~reset;
    end

    // Staged sample as seen on the bus, sign-extended by assignment
    function automatic logic [31:0] expected_readback(input logic [`SD_SAMPLE_W-1:0] v);
        int s;
        s = $signed(v);
        return s;
    endfunction

    // Ones fraction of a first-order balance around +-delta
    function automatic real expected_density(input int x);
        return real'(x + `SD_DELTA) / real'(2 * `SD_DELTA);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic check_density(input string name, input real expected, input real actual);
        real diff;
        diff = actual - expected;
        if (diff > 0.02 || diff < -0.02) begin
            $display("error at %0t: %s density expected %0.4f got %0.4f",
                     $time, name, expected, actual);
            err_cnt++;
        end
    endtask

    // ------------------------------
    // Wishbone host
    // ------------------------------
    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
        int waited;
        waited = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            @(negedge reset);
            waited++;
        end while (!wb_rsp.ack && waited < ack_timeout);
        if (!wb_rsp.ack) begin
            $display("no ack for write to address %h after %0d cycles", adr, waited);
            err_cnt++;
        end
        wb_req = '0;
        // Strobe low for one cycle between transfers
        @(negedge reset);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
        int waited;
        waited = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = '0;
        do begin
            @(negedge reset);
            waited++;
        end while (!wb_rsp.ack && waited < ack_timeout);
        dat = wb_rsp.dat;
        if (!wb_rsp.ack) begin
            $display("no ack for read from address %h after %0d cycles", adr, waited);
            err_cnt++;
        end
        wb_req = '0;
        @(negedge reset);
    endtask

    task automatic stage_sample(input logic chan, input logic [31:0] value);
        if (chan) begin
            wb_write(adr_right, value);
            shadow_right = value[`SD_SAMPLE_W-1:0];
        end else begin
            wb_write(adr_left, value);
            shadow_left = value[`SD_SAMPLE_W-1:0];
        end
    endtask

    // Poll status bit 0 until the sequencer has taken the frame
    task automatic wait_taken();
        logic [31:0] status;
        int          polls;
        polls = 0;
        do begin
            wb_read(adr_status, status);
            polls++;
        end while (status[0] && polls < poll_limit);
        if (status[0]) begin
            $display("pending never cleared after %0d status reads", polls);
            err_cnt++;
        end
    endtask

    // One commit, then both outputs land before the sequencer is back at wait
    task automatic run_frame();
        wb_write(adr_commit, 32'd0);
        wait_taken();
        repeat (`SD_UCODE_LEN) @(negedge reset);
    endtask

    // ------------------------------
    // Test sequences
    // ------------------------------
    task automatic density_run(input int x_left, input int x_right);
        int ones_l;
        int ones_r;
        int f;
        stage_sample(1'b0, 32'(x_left));
        stage_sample(1'b1, 32'(x_right));
        repeat (settle_frames) run_frame();
        ones_l = 0;
        ones_r = 0;
        for (f = 0; f < count_frames; f++) begin
            run_frame();
            ones_l += int'(dout_l);
            ones_r += int'(dout_r);
        end
        check_density("dout_l", expected_density(x_left), real'(ones_l) / count_frames);
        check_density("dout_r", expected_density(x_right), real'(ones_r) / count_frames);
    endtask

    task automatic overrun_test();
        logic [31:0] status;
        wait_taken();
        repeat (`SD_UCODE_LEN) @(negedge reset);
        // Taken at once, keeps the sequencer busy for a whole frame
        wb_write(adr_commit, 32'd0);
        // Second waits as pending, third overwrites it
        wb_write(adr_commit, 32'd0);
        wb_write(adr_commit, 32'd0);
        wb_read(adr_status, status);
        check_value("status", 32'h3, status);
        // Overrun cleared by the read, frame still pending
        wb_read(adr_status, status);
        check_value("status", 32'h1, status);
        wait_taken();
        wb_read(adr_status, status);
        check_value("status", 32'h0, status);
    endtask

    task automatic random_traffic();
        logic [31:0] value;
        logic [31:0] rdata;
        int          op;
        int          i;
        for (i = 0; i < random_ops; i++) begin
            op    = $urandom_range(0, 5);
            value = $urandom;
            case (op)
                0: stage_sample(1'b0, value);
                1: stage_sample(1'b1, value);
                2: begin
                    wb_read(adr_left, rdata);
                    check_value("left sample", expected_readback(shadow_left), rdata);
                end
                3: begin
                    wb_read(adr_right, rdata);
                    check_value("right sample", expected_readback(shadow_right), rdata);
                end
                4: wb_read(adr_status, rdata);
                default: wb_write(adr_commit, value);
            endcase
            repeat ($urandom_range(0, 3)) @(negedge reset);
        end
    endtask

    initial begin
        logic [31:0] status;
        void'($urandom(32'h17d5));
        err_cnt      = 0;
        shadow_left  = '0;
        shadow_right = '0;
        wb_req       = '0;
        clk          = 1'b1;
        repeat (5) @(negedge reset);
        clk = 1'b0;

        wb_read(adr_status, status);
        check_value("status", 32'h0, status);
        check_value("dout_l", 32'h0, 32'(dout_l));
        check_value("dout_r", 32'h0, 32'(dout_r));

        // Clean loop state first, random traffic can overload the modulator
        density_run(0, 0);
        density_run('h0c000, -'h0c000);
        density_run(-'h0c000, 'h0c000);
        overrun_test();
        random_traffic();
        wait_taken();
        repeat (`SD_UCODE_LEN) @(negedge reset);

        $display("error count: %0d in testbench, %0d in assertions",
                 err_cnt, UUT.u_chk.fail_cnt);
        if (err_cnt == 0 && UUT.u_chk.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
src/sd_dac_pkg.sv
src/sd_wb_regs.sv
src/sd_sequencer.sv
src/sd_accum_alu.sv
src/sd_loop_state.sv
src/sd_dac_top.sv
tb/sd_dac_chk.sv
tb/sd_dac_tb.sv

// File: Makefile
# Verilator build and run for the sigma-delta DAC testbench

VERILATOR ?= verilator
TOP       ?= sd_dac_tb
LOG       ?= sim.log
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Everything OK" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
